/* source/dac_config.svh */
`ifndef DAC_CONFIG_SVH
`define DAC_CONFIG_SVH

// System clocks per DAC clock phase
`define DAC_HALF_BIT 30

// Quad DAC, fixed by the part
`define DAC_NUM_CHAN 4

// Data bits per channel
`define DAC_CODE_W 8

// Serial command word, A1 A0 RNG D7..D0
`define DAC_WORD_W 11

`endif

/* source/dac_types_pkg.sv */
`default_nettype none

`include "dac_config.svh"

package dac_types_pkg;

    // Output code for one channel
    typedef logic [`DAC_CODE_W-1:0] dac_code_t;

    // Channel address A1 A0
    typedef logic [$clog2(`DAC_NUM_CHAN)-1:0] dac_chan_t;

    // Range select, 1 doubles the output
    typedef logic dac_rng_t;

    // Command word as shifted, MSB first
    typedef logic [`DAC_WORD_W-1:0] dac_word_t;

    function automatic dac_word_t dac_make_word(dac_chan_t chan, dac_rng_t rng, dac_code_t code);
        return {chan, rng, code};
    endfunction

endpackage

`default_nettype wire

/* source/dac_ctrl_pkg.sv */
`default_nettype none

package dac_ctrl_pkg;

    typedef enum logic [2:0] {
        DRV_IDLE,
        DRV_SHIFT,
        DRV_LOAD_LO,
        DRV_LOAD_HI,
        DRV_LDAC_LO,
        DRV_LDAC_HI
    } drv_state_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_PICK,
        SEQ_WAIT_DONE
    } seq_state_t;

endpackage

`default_nettype wire

/* source/tlc5620_drive.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dac_config.svh"

module tlc5620_drive (
    input  logic                     sys_clk,
    input  logic                     sys_rst_n,
    input  logic                     frame_start,
    input  dac_types_pkg::dac_word_t frame_word,
    input  logic                     frame_ldac,
    output logic                     frame_done,
    output logic                     tlc5620_clk,
    output logic                     tlc5620_data,
    output logic                     tlc5620_load,
    output logic                     tlc5620_ldac
);
    import dac_types_pkg::*;
    import dac_ctrl_pkg::*;

    localparam int CNT_W = (`DAC_HALF_BIT > 1) ? $clog2(`DAC_HALF_BIT) : 1;
    localparam int BIT_W = $clog2(`DAC_WORD_W + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`DAC_HALF_BIT - 1);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`DAC_WORD_W);

    drv_state_t       state;
    logic [CNT_W-1:0] cnt;          // Cycles within a phase
    logic [BIT_W-1:0] bit_idx;      // Bits already clocked out
    logic             ldac_req;
    dac_word_t        shift_q;
    logic             phase_end;

    assign phase_end = (cnt == CNT_LAST);

    // Last cycle of the frame, with or without the LDAC pulse
    assign frame_done = phase_end &&
                        (((state == DRV_LOAD_HI) && !ldac_req) || (state == DRV_LDAC_HI));

    always_ff @(posedge sys_clk) begin
        if (frame_start) begin
            shift_q <= frame_word;
        end else if ((state == DRV_SHIFT) && phase_end && tlc5620_clk) begin
            shift_q <= {shift_q[`DAC_WORD_W-2:0], 1'b0};  // Next bit after the fall
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cnt <= '0;
        end else if (frame_start) begin
            cnt <= CNT_W'(1);       // Start cycle counts as first lead-in cycle
        end else if ((state == DRV_IDLE) || phase_end) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state        <= DRV_IDLE;
            bit_idx      <= '0;
            ldac_req     <= 1'b0;
            tlc5620_clk  <= 1'b0;
            tlc5620_data <= 1'b0;
            tlc5620_load <= 1'b1;
            tlc5620_ldac <= 1'b1;
        end else begin
            case (state)
                DRV_IDLE: begin
                    if (frame_start) begin
                        state    <= DRV_SHIFT;
                        bit_idx  <= '0;
                        ldac_req <= frame_ldac;
                    end
                end
                DRV_SHIFT: begin
                    if (phase_end) begin
                        if (tlc5620_clk) begin
                            tlc5620_clk <= 1'b0;        // DAC samples here
                            bit_idx     <= bit_idx + 1'b1;
                        end else if (bit_idx == BIT_LAST) begin
                            tlc5620_load <= 1'b0;
                            tlc5620_data <= 1'b0;
                            state        <= DRV_LOAD_LO;
                        end else begin
                            tlc5620_clk  <= 1'b1;
                            tlc5620_data <= shift_q[`DAC_WORD_W-1];
                        end
                    end
                end
                DRV_LOAD_LO: begin
                    if (phase_end) begin
                        tlc5620_load <= 1'b1;
                        state        <= DRV_LOAD_HI;
                    end
                end
                DRV_LOAD_HI: begin
                    if (phase_end) begin
                        if (ldac_req) begin
                            tlc5620_ldac <= 1'b0;   // Update all outputs
                            state        <= DRV_LDAC_LO;
                        end else begin
                            state <= DRV_IDLE;
                        end
                    end
                end
                DRV_LDAC_LO: begin
                    if (phase_end) begin
                        tlc5620_ldac <= 1'b1;
                        state        <= DRV_LDAC_HI;
                    end
                end
                DRV_LDAC_HI: begin
                    if (phase_end) begin
                        state <= DRV_IDLE;
                    end
                end
                default: begin
                    state <= DRV_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/dac_channel_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dac_config.svh"

module dac_channel_sequencer (
    input  logic                     sys_clk,
    input  logic                     sys_rst_n,
    input  logic                     wr_en,
    input  dac_types_pkg::dac_chan_t wr_chan,
    input  dac_types_pkg::dac_rng_t  wr_rng,
    input  dac_types_pkg::dac_code_t wr_code,
    input  logic [`DAC_NUM_CHAN-1:0] chan_enable,
    input  logic                     frame_done,
    output logic                     frame_start,
    output dac_types_pkg::dac_word_t frame_word,
    output logic                     frame_ldac
);
    import dac_types_pkg::*;
    import dac_ctrl_pkg::*;

    seq_state_t state;
    dac_code_t  code_q [`DAC_NUM_CHAN];
    dac_rng_t   rng_q  [`DAC_NUM_CHAN];
    dac_chan_t  last_chan;          // Channel of the previous frame
    dac_chan_t  next_chan;
    dac_chan_t  cand;
    logic       next_found;
    logic       sweep_end;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            for (int i = 0; i < `DAC_NUM_CHAN; i++) begin
                code_q[i] <= '0;
                rng_q[i]  <= '0;
            end
        end else if (wr_en) begin
            code_q[wr_chan] <= wr_code;
            rng_q[wr_chan]  <= wr_rng;
        end
    end

    // Round-robin search starting after the last channel sent
    always_comb begin
        next_found = 1'b0;
        next_chan  = last_chan;
        cand       = last_chan;
        for (int i = 1; i <= `DAC_NUM_CHAN; i++) begin
            cand = last_chan + dac_chan_t'(i);
            if (!next_found && chan_enable[cand]) begin
                next_found = 1'b1;
                next_chan  = cand;
            end
        end
    end

    // No enabled channel above this one closes the sweep
    always_comb begin
        sweep_end = 1'b1;
        for (int i = 0; i < `DAC_NUM_CHAN; i++) begin
            if (chan_enable[i] && (i > int'(next_chan))) begin
                sweep_end = 1'b0;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if ((state == SEQ_PICK) && next_found) begin
            frame_word <= dac_make_word(next_chan, rng_q[next_chan], code_q[next_chan]);
            frame_ldac <= sweep_end;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state       <= SEQ_IDLE;
            last_chan   <= dac_chan_t'(`DAC_NUM_CHAN - 1);  // First sweep starts at 0
            frame_start <= 1'b0;
        end else begin
            frame_start <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (|chan_enable) begin
                        state <= SEQ_PICK;
                    end
                end
                SEQ_PICK: begin
                    if (next_found) begin
                        frame_start <= 1'b1;
                        last_chan   <= next_chan;
                        state       <= SEQ_WAIT_DONE;
                    end else begin
                        state <= SEQ_IDLE;      // Mask cleared meanwhile
                    end
                end
                SEQ_WAIT_DONE: begin
                    if (frame_done) begin
                        state <= SEQ_PICK;
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/dac_subsystem_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dac_config.svh"

module dac_subsystem_top (
    input  logic                     sys_clk,
    input  logic                     sys_rst_n,
    input  logic                     wr_en,
    input  dac_types_pkg::dac_chan_t wr_chan,
    input  dac_types_pkg::dac_rng_t  wr_rng,
    input  dac_types_pkg::dac_code_t wr_code,
    input  logic [`DAC_NUM_CHAN-1:0] chan_enable,
    output logic                     tlc5620_clk,
    output logic                     tlc5620_data,
    output logic                     tlc5620_load,
    output logic                     tlc5620_ldac
);
    import dac_types_pkg::*;

    logic      frame_start;
    dac_word_t frame_word;
    logic      frame_ldac;
    logic      frame_done;

    dac_channel_sequencer u_sequencer (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .wr_en       (wr_en),
        .wr_chan     (wr_chan),
        .wr_rng      (wr_rng),
        .wr_code     (wr_code),
        .chan_enable (chan_enable),
        .frame_done  (frame_done),
        .frame_start (frame_start),
        .frame_word  (frame_word),
        .frame_ldac  (frame_ldac)
    );

    tlc5620_drive u_drive (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .frame_start  (frame_start),
        .frame_word   (frame_word),
        .frame_ldac   (frame_ldac),
        .frame_done   (frame_done),
        .tlc5620_clk  (tlc5620_clk),
        .tlc5620_data (tlc5620_data),
        .tlc5620_load (tlc5620_load),
        .tlc5620_ldac (tlc5620_ldac)
    );

endmodule

`default_nettype wire

/* dv/dac_protocol_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module dac_protocol_properties (
    input logic sys_clk,
    input logic sys_rst_n,
    input logic frame_start,
    input logic frame_done,
    input logic tlc5620_clk,
    input logic tlc5620_data,
    input logic tlc5620_load,
    input logic tlc5620_ldac
);
    logic frame_busy;   // Between start and done

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            frame_busy <= 1'b0;
        end else if (frame_start) begin
            frame_busy <= 1'b1;
        end else if (frame_done) begin
            frame_busy <= 1'b0;
        end
    end

    data_stable_clk_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (tlc5620_clk && $past(tlc5620_clk)) |-> $stable(tlc5620_data))
        else $error("tlc5620_data changed while tlc5620_clk was high");

    load_ldac_exclusive: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        !(!tlc5620_load && !tlc5620_ldac))
        else $error("LOAD and LDAC low at the same time");

    load_clk_low: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        $fell(tlc5620_load) |-> !tlc5620_clk)
        else $error("LOAD fell while tlc5620_clk was high");

    no_frame_overlap: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        frame_start |-> !frame_busy)
        else $error("frame_start raised while a frame was in progress");

endmodule

`default_nettype wire

/* dv/tb_dac_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dac_config.svh"

module tb_dac_subsystem;
    import dac_types_pkg::*;

    localparam int H = `DAC_HALF_BIT;
    localparam int NUM_TESTS = 5;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 8 * 27 * H + 4000;

    logic                     sys_clk;
    logic                     sys_rst_n;
    logic                     wr_en;
    dac_chan_t                wr_chan;
    dac_rng_t                 wr_rng;
    dac_code_t                wr_code;
    logic [`DAC_NUM_CHAN-1:0] chan_enable;
    logic                     tlc5620_clk;
    logic                     tlc5620_data;
    logic                     tlc5620_load;
    logic                     tlc5620_ldac;

    int          err_cnt = 0;
    int          fail_cnt = 0;
    int          cycle_cnt = 0;
    int          errs_before;
    int          base;              // First captured word of the current test
    logic [31:0] lcg_state = 32'h8980da8a;
    dac_code_t   exp_code [`DAC_NUM_CHAN];
    dac_rng_t    exp_rng  [`DAC_NUM_CHAN];

    dac_word_t   model_shift = '0;
    dac_word_t   model_latch [`DAC_NUM_CHAN] = '{default: '0};
    dac_code_t   model_out   [`DAC_NUM_CHAN] = '{default: '0};
    dac_word_t   cap_words [$];
    int          ldac_marks [$];    // Words loaded when LDAC fell

    dac_subsystem_top DUT (.*);

    bind tlc5620_drive dac_protocol_properties u_properties (
        .sys_clk     (sys_clk),     .sys_rst_n    (sys_rst_n),
        .frame_start (frame_start), .frame_done   (frame_done),
        .tlc5620_clk (tlc5620_clk), .tlc5620_data (tlc5620_data),
        .tlc5620_load(tlc5620_load), .tlc5620_ldac (tlc5620_ldac)
    );

    initial begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // TLC5620 model, samples data on the falling DAC clock
    always @(negedge tlc5620_clk) begin
        if (sys_rst_n)
            model_shift <= {model_shift[`DAC_WORD_W-2:0], tlc5620_data};
    end

    always @(negedge tlc5620_load) begin
        if (sys_rst_n) begin
            model_latch[model_shift[`DAC_WORD_W-1 -: 2]] = model_shift;
            cap_words.push_back(model_shift);
        end
    end

    always @(negedge tlc5620_ldac) begin
        if (sys_rst_n) begin
            foreach (model_out[i]) begin
                model_out[i] = model_latch[i][`DAC_CODE_W-1:0];  // All outputs at once
            end
            ldac_marks.push_back(cap_words.size());
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic ldac_followed(int idx);
        foreach (ldac_marks[i]) begin
            if (ldac_marks[i] == idx + 1)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic check_word(string name, dac_word_t exp, dac_word_t act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_code(string name, dac_code_t exp, dac_code_t act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
            err_cnt++;
        end
    endtask

    // Word layout is A1 A0, RNG, D7..D0
    task automatic check_frame(string name, int idx, int chan, logic ldac_exp);
        check_word($sformatf("%s word %0d", name, idx - base),
                   {dac_chan_t'(chan), exp_rng[chan], exp_code[chan]}, cap_words[idx]);
        check_flag($sformatf("%s ldac %0d", name, idx - base), ldac_exp, ldac_followed(idx));
    endtask

    task automatic write_reg(int chan, dac_rng_t rng, dac_code_t code);
        exp_code[chan] = code;
        exp_rng[chan]  = rng;
        @(posedge sys_clk);
        #5;
        wr_en   = 1'b1;
        wr_chan = dac_chan_t'(chan);
        wr_rng  = rng;
        wr_code = code;
        @(posedge sys_clk);
        #5;
        wr_en = 1'b0;
    endtask

    task automatic write_random(int chan);
        logic [31:0] r;
        r = next_random();
        write_reg(chan, r[9], r[23:16]);
    endtask

    task automatic set_enable(logic [`DAC_NUM_CHAN-1:0] mask);
        @(posedge sys_clk);
        #5;
        chan_enable = mask;
    endtask

    task automatic wait_frames(int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(negedge sys_clk);
            if (DUT.frame_done)
                seen++;
        end
    endtask

    task automatic start_test();
        errs_before = err_cnt;
        @(posedge sys_clk);
        #5;
        sys_rst_n   = 1'b0;
        chan_enable = '0;
        repeat (4) @(posedge sys_clk);
        #5;
        sys_rst_n = 1'b1;
        base = cap_words.size();
    endtask

    task automatic finish_test(string name);
        if (err_cnt != errs_before)
            fail_cnt++;
        $display("Test %s: %s", name, (err_cnt == errs_before) ? "ok" : "FAILED");
    endtask

    task automatic test_reset_idle();
        logic active;
        active = 1'b0;
        start_test();
        repeat (2 * 27 * H) begin
            @(negedge sys_clk);
            if (tlc5620_clk || !tlc5620_load || !tlc5620_ldac)
                active = 1'b1;
        end
        check_flag("reset_idle pins active", 1'b0, active);
        check_flag("reset_idle frames seen", 1'b0, cap_words.size() != base);
        finish_test("reset_idle");
    endtask

    task automatic test_single_channel();
        int chan;
        start_test();
        chan = int'(next_random() % 32'd4);
        write_random(chan);
        set_enable(4'(1 << chan));
        wait_frames(3);
        set_enable('0);
        check_flag("single_chan frame count", 1'b1, cap_words.size() == base + 3);
        for (int i = 0; i < 3; i++) begin
            check_frame("single_chan", base + i, chan, 1'b1);
        end
        check_code("single_chan output", exp_code[chan], model_out[chan]);
        finish_test("single_chan");
    endtask

    task automatic test_full_sweep();
        dac_code_t old_out [`DAC_NUM_CHAN];
        start_test();
        for (int i = 0; i < `DAC_NUM_CHAN; i++) begin
            write_random(i);
        end
        old_out = model_out;
        set_enable('1);
        wait_frames(3);
        for (int i = 0; i < `DAC_NUM_CHAN; i++) begin
            check_code($sformatf("full_sweep held %0d", i), old_out[i], model_out[i]);
        end
        wait_frames(1);
        set_enable('0);
        for (int i = 0; i < `DAC_NUM_CHAN; i++) begin
            check_frame("full_sweep", base + i, i, i == 3);
            check_code($sformatf("full_sweep output %0d", i), exp_code[i], model_out[i]);
        end
        finish_test("full_sweep");
    endtask

    task automatic test_skip_disabled();
        start_test();
        for (int i = 0; i < `DAC_NUM_CHAN; i++) begin
            write_random(i);
        end
        set_enable(4'b1010);
        wait_frames(4);
        set_enable('0);
        check_flag("skip_disabled frame count", 1'b1, cap_words.size() == base + 4);
        for (int i = 0; i < 4; i++) begin
            check_frame("skip_disabled", base + i, (i % 2 == 0) ? 1 : 3, i % 2 == 1);
        end
        finish_test("skip_disabled");
    endtask

    task automatic test_update_between();
        int        mark;
        logic      got_new;
        dac_chan_t chan;
        dac_word_t old_word;
        dac_word_t new_word;
        got_new = 1'b0;
        start_test();
        for (int i = 0; i < `DAC_NUM_CHAN; i++) begin
            write_random(i);
        end
        old_word = {dac_chan_t'(1), exp_rng[1], exp_code[1]};
        set_enable('1);
        wait_frames(2);
        mark = cap_words.size();
        write_reg(1, exp_rng[1], ~exp_code[1]);     // Rewrite while frames run
        new_word = {dac_chan_t'(1), exp_rng[1], exp_code[1]};
        wait_frames(8);
        set_enable('0);
        for (int i = base; i < cap_words.size(); i++) begin
            chan = cap_words[i][`DAC_WORD_W-1 -: 2];
            if (chan != dac_chan_t'(1)) begin
                check_frame("update", i, int'(chan), chan == dac_chan_t'(3));
            end else begin
                check_flag($sformatf("update chan1 written value %0d", i - base), 1'b1,
                           cap_words[i] == old_word || cap_words[i] == new_word);
                if (i >= mark && cap_words[i] == new_word)
                    got_new = 1'b1;
            end
        end
        check_flag("update new code within two sweeps", 1'b1, got_new);
        finish_test("update");
    endtask

    initial begin
        sys_rst_n   = 1'b0;
        wr_en       = 1'b0;
        wr_chan     = '0;
        wr_rng      = '0;
        wr_code     = '0;
        chan_enable = '0;
        test_reset_idle();
        test_single_channel();
        test_full_sweep();
        test_skip_disabled();
        test_update_between();
        $display("Tests: %0d, failed: %0d, errors: %0d", NUM_TESTS, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+source
source/dac_types_pkg.sv
source/dac_ctrl_pkg.sv
source/tlc5620_drive.sv
source/dac_channel_sequencer.sv
source/dac_subsystem_top.sv
dv/dac_protocol_properties.sv
dv/tb_dac_subsystem.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_dac_subsystem
RTL_TOP    ?= dac_subsystem_top
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall -Isource
RTL_SRCS   ?= source/dac_types_pkg.sv source/dac_ctrl_pkg.sv source/tlc5620_drive.sv \
              source/dac_channel_sequencer.sv source/dac_subsystem_top.sv
FAIL_MSG   ?= Simulation failed
PASS_MSG   ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run FAILED, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Run incomplete, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
